/* icache_defs.svh */
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// fetch side address
`define ICACHE_ADDR_BITS    32

// address split  tag[31:12] set[11:6] bank[5:4]
`define ICACHE_OFFSET_BITS  6
`define ICACHE_BANK_BITS    2
`define ICACHE_SET_BITS     6
`define ICACHE_TAG_BITS     20

// geometry
`define ICACHE_WAYS         2
`define ICACHE_BANKS        4
`define ICACHE_SETS         64

// data widths
`define ICACHE_FETCH_BITS   128
`define ICACHE_LINE_BITS    512

// replacement lfsr start value
`define ICACHE_LFSR_SEED    8'hFF

`endif

/* icache_pkg.sv */
`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

    // controller states
    typedef enum logic [2:0] {
        IDLE,        // waiting for a fetch
        LOOKUP,      // tags valid, hit compare
        READ_CACHE,  // hit data out
        MEM_REQ,     // line request pending
        MEM_WAIT,    // line request accepted
        REFILL,      // refilled word out
        DRAIN        // flushed, waiting for the stale line
    } icache_state_e;

    typedef logic [`ICACHE_ADDR_BITS-1:0]  addr_t;
    typedef logic [`ICACHE_SET_BITS-1:0]   set_t;
    typedef logic [`ICACHE_TAG_BITS-1:0]   tag_t;
    typedef logic [`ICACHE_BANK_BITS-1:0]  bank_t;
    typedef logic [`ICACHE_WAYS-1:0]       way_oh_t;
    typedef logic [`ICACHE_FETCH_BITS-1:0] fetch_t;
    typedef logic [`ICACHE_LINE_BITS-1:0]  line_t;

endpackage

`default_nettype wire

/* icache_tag_array.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_defs.svh"

module icache_tag_array (
    input  wire                  clock,
    input  wire                  reset_n,
    input  logic                 read_en,
    input  icache_pkg::set_t     read_set,
    input  logic                 write_en,
    input  icache_pkg::set_t     write_set,
    input  icache_pkg::way_oh_t  write_way,
    input  icache_pkg::tag_t     write_tag,
    output icache_pkg::tag_t     read_tags [`ICACHE_WAYS],
    output icache_pkg::way_oh_t  read_valid
);

    icache_pkg::tag_t    tag_mem   [`ICACHE_SETS][`ICACHE_WAYS];
    icache_pkg::way_oh_t valid_mem [`ICACHE_SETS];

    // tag storage with one way written per refill
    always_ff @(posedge clock) begin
        if (write_en) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (write_way[w]) begin
                    tag_mem[write_set][w] <= write_tag;
                end
            end
        end
        if (read_en) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                read_tags[w] <= tag_mem[read_set][w];
            end
        end
    end

    // valid bits cleared on reset
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid_mem[s] <= '0;
            end
            read_valid <= '0;
        end else begin
            if (write_en) begin
                valid_mem[write_set] <= valid_mem[write_set] | write_way;
            end
            if (read_en) begin
                read_valid <= valid_mem[read_set];  // both ways of the set
            end
        end
    end

endmodule

`default_nettype wire

/* icache_data_array.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_defs.svh"

module icache_data_array (
    input  wire                  clock,
    input  logic                 read_en,
    input  icache_pkg::set_t     read_set,
    input  icache_pkg::way_oh_t  read_way,
    input  icache_pkg::bank_t    read_bank,
    input  logic                 write_en,
    input  icache_pkg::set_t     write_set,
    input  icache_pkg::way_oh_t  write_way,
    input  icache_pkg::line_t    write_line,
    output icache_pkg::fetch_t   read_data
);

    // four fetch-wide banks per way and set
    icache_pkg::fetch_t bank_mem [`ICACHE_SETS][`ICACHE_WAYS][`ICACHE_BANKS];

    icache_pkg::fetch_t way_word [`ICACHE_WAYS];  // chosen bank of each way

    // bank b of the line sits at bits 128*b and up
    always_ff @(posedge clock) begin
        if (write_en) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (write_way[w]) begin
                    for (int b = 0; b < `ICACHE_BANKS; b++) begin
                        bank_mem[write_set][w][b] <=
                            write_line[b*`ICACHE_FETCH_BITS +: `ICACHE_FETCH_BITS];
                    end
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_word[w] = bank_mem[read_set][w][read_bank];
        end
    end

    // registered one-hot way mux
    always_ff @(posedge clock) begin
        if (read_en) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (read_way[w]) begin
                    read_data <= way_word[w];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* icache_victim_select.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_defs.svh"

module icache_victim_select (
    input  wire                  clock,
    input  wire                  reset_n,
    input  icache_pkg::way_oh_t  way_valid,
    output icache_pkg::way_oh_t  victim_way
);

    logic [7:0] lfsr;
    logic       lfsr_fb;

    // x^8 + x^6 + x^5 + x^4 + 1
    assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lfsr <= `ICACHE_LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6:0], lfsr_fb};  // free running
        end
    end

    always_comb begin
        logic found;
        found      = 1'b0;
        victim_way = '0;
        // lowest invalid way wins
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (!way_valid[w] && !found) begin
                victim_way[w] = 1'b1;
                found         = 1'b1;
            end
        end
        // set full so the lfsr picks the way
        if (!found) begin
            victim_way[lfsr[0]] = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* icache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_defs.svh"

module icache_ctrl (
    input  wire                  clock,
    input  wire                  reset_n,
    input  wire                  flush,
    input  logic                 fetch_req_valid,
    output logic                 fetch_req_ready,
    input  icache_pkg::addr_t    fetch_req_addr,
    output logic                 fetch_done,
    output icache_pkg::fetch_t   fetch_data,
    output logic                 mem_req_valid,
    input  logic                 mem_req_ready,
    output icache_pkg::addr_t    mem_req_addr,
    input  logic                 mem_resp_valid,
    input  icache_pkg::line_t    mem_resp_data,
    output logic                 tag_read_en,
    output icache_pkg::set_t     tag_read_set,
    output logic                 tag_write_en,
    output icache_pkg::set_t     tag_write_set,
    output icache_pkg::way_oh_t  tag_write_way,
    output icache_pkg::tag_t     tag_write_tag,
    input  icache_pkg::tag_t     tag_read_tags [`ICACHE_WAYS],
    input  icache_pkg::way_oh_t  tag_read_valid,
    output logic                 data_read_en,
    output icache_pkg::set_t     data_read_set,
    output icache_pkg::way_oh_t  data_read_way,
    output icache_pkg::bank_t    data_read_bank,
    output logic                 data_write_en,
    output icache_pkg::set_t     data_write_set,
    output icache_pkg::way_oh_t  data_write_way,
    output icache_pkg::line_t    data_write_line,
    input  icache_pkg::fetch_t   data_read_data,
    input  icache_pkg::way_oh_t  victim_way
);

    icache_pkg::icache_state_e state;
    icache_pkg::icache_state_e state_next;

    icache_pkg::addr_t   req_addr;     // captured at acceptance
    icache_pkg::set_t    req_set;
    icache_pkg::tag_t    req_tag;
    icache_pkg::bank_t   req_bank;
    icache_pkg::way_oh_t hit_way;
    icache_pkg::way_oh_t sel_way;      // hit way or refill victim
    icache_pkg::fetch_t  refill_data;  // requested bank of the new line
    logic                lookup_hit;
    logic                req_fire;
    logic                refill_fire;

    assign req_set  = req_addr[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
    assign req_tag  = req_addr[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
    assign req_bank = req_addr[`ICACHE_OFFSET_BITS-1 -: `ICACHE_BANK_BITS];

    assign fetch_req_ready = (state == icache_pkg::IDLE) && !flush;
    assign req_fire        = fetch_req_valid && fetch_req_ready;

    // line arrives for a live miss
    assign refill_fire = (state == icache_pkg::MEM_WAIT) && mem_resp_valid && !flush;

    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_way[w] = tag_read_valid[w] && (tag_read_tags[w] == req_tag);
        end
    end
    assign lookup_hit = |hit_way;

    always_comb begin
        state_next = state;
        case (state)
            icache_pkg::IDLE: begin
                if (req_fire) state_next = icache_pkg::LOOKUP;
            end
            icache_pkg::LOOKUP: begin
                if (flush)           state_next = icache_pkg::IDLE;
                else if (lookup_hit) state_next = icache_pkg::READ_CACHE;
                else                 state_next = icache_pkg::MEM_REQ;
            end
            icache_pkg::MEM_REQ: begin
                if (mem_req_ready) begin
                    // accepted request must still be drained on flush
                    state_next = flush ? icache_pkg::DRAIN : icache_pkg::MEM_WAIT;
                end else if (flush) begin
                    state_next = icache_pkg::IDLE;
                end
            end
            icache_pkg::MEM_WAIT: begin
                if (mem_resp_valid) begin
                    state_next = flush ? icache_pkg::IDLE : icache_pkg::REFILL;
                end else if (flush) begin
                    state_next = icache_pkg::DRAIN;
                end
            end
            icache_pkg::DRAIN: begin
                if (mem_resp_valid) state_next = icache_pkg::IDLE;  // stale line dropped
            end
            default: state_next = icache_pkg::IDLE;  // READ_CACHE, REFILL
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= icache_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clock) begin
        if (req_fire) begin
            req_addr <= fetch_req_addr;
        end
        if (state == icache_pkg::LOOKUP) begin
            sel_way <= lookup_hit ? hit_way : victim_way;
        end
        if (refill_fire) begin
            refill_data <= mem_resp_data[req_bank*`ICACHE_FETCH_BITS +: `ICACHE_FETCH_BITS];
        end
    end

    // tag read starts on the live address
    assign tag_read_en   = req_fire;
    assign tag_read_set  = fetch_req_addr[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
    assign tag_write_en  = refill_fire;
    assign tag_write_set = req_set;
    assign tag_write_way = sel_way;
    assign tag_write_tag = req_tag;

    assign data_read_en    = (state == icache_pkg::LOOKUP) && lookup_hit && !flush;
    assign data_read_set   = req_set;
    assign data_read_way   = hit_way;
    assign data_read_bank  = req_bank;
    assign data_write_en   = refill_fire;
    assign data_write_set  = req_set;
    assign data_write_way  = sel_way;
    assign data_write_line = mem_resp_data;

    assign mem_req_valid = (state == icache_pkg::MEM_REQ);
    assign mem_req_addr  = {req_addr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS],
                            {`ICACHE_OFFSET_BITS{1'b0}}};  // line aligned

    assign fetch_done = ((state == icache_pkg::READ_CACHE) ||
                         (state == icache_pkg::REFILL)) && !flush;

    always_comb begin
        case (state)
            icache_pkg::READ_CACHE: fetch_data = data_read_data;
            icache_pkg::REFILL:     fetch_data = refill_data;
            default:                fetch_data = '0;
        endcase
    end

endmodule

`default_nettype wire

/* icache_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_defs.svh"

module icache_top (
    input  wire                 clock,
    input  wire                 reset_n,
    input  wire                 flush,
    input  logic                fetch_req_valid,
    output logic                fetch_req_ready,
    input  icache_pkg::addr_t   fetch_req_addr,
    output logic                fetch_done,
    output icache_pkg::fetch_t  fetch_data,
    output logic                mem_req_valid,
    input  logic                mem_req_ready,
    output icache_pkg::addr_t   mem_req_addr,
    input  logic                mem_resp_valid,
    input  icache_pkg::line_t   mem_resp_data
);

    logic                tag_read_en;
    icache_pkg::set_t    tag_read_set;
    logic                tag_write_en;
    icache_pkg::set_t    tag_write_set;
    icache_pkg::way_oh_t tag_write_way;
    icache_pkg::tag_t    tag_write_tag;
    icache_pkg::tag_t    tag_read_tags [`ICACHE_WAYS];
    icache_pkg::way_oh_t tag_read_valid;

    logic                data_read_en;
    icache_pkg::set_t    data_read_set;
    icache_pkg::way_oh_t data_read_way;
    icache_pkg::bank_t   data_read_bank;
    logic                data_write_en;
    icache_pkg::set_t    data_write_set;
    icache_pkg::way_oh_t data_write_way;
    icache_pkg::line_t   data_write_line;
    icache_pkg::fetch_t  data_read_data;

    icache_pkg::way_oh_t victim_way;

    icache_ctrl icache_ctrl_inst (
        .clock           (clock),
        .reset_n         (reset_n),
        .flush           (flush),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req_ready (fetch_req_ready),
        .fetch_req_addr  (fetch_req_addr),
        .fetch_done      (fetch_done),
        .fetch_data      (fetch_data),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_req_addr    (mem_req_addr),
        .mem_resp_valid  (mem_resp_valid),
        .mem_resp_data   (mem_resp_data),
        .tag_read_en     (tag_read_en),
        .tag_read_set    (tag_read_set),
        .tag_write_en    (tag_write_en),
        .tag_write_set   (tag_write_set),
        .tag_write_way   (tag_write_way),
        .tag_write_tag   (tag_write_tag),
        .tag_read_tags   (tag_read_tags),
        .tag_read_valid  (tag_read_valid),
        .data_read_en    (data_read_en),
        .data_read_set   (data_read_set),
        .data_read_way   (data_read_way),
        .data_read_bank  (data_read_bank),
        .data_write_en   (data_write_en),
        .data_write_set  (data_write_set),
        .data_write_way  (data_write_way),
        .data_write_line (data_write_line),
        .data_read_data  (data_read_data),
        .victim_way      (victim_way)
    );

    icache_tag_array icache_tag_array_inst (
        .clock      (clock),
        .reset_n    (reset_n),
        .read_en    (tag_read_en),
        .read_set   (tag_read_set),
        .write_en   (tag_write_en),
        .write_set  (tag_write_set),
        .write_way  (tag_write_way),
        .write_tag  (tag_write_tag),
        .read_tags  (tag_read_tags),
        .read_valid (tag_read_valid)
    );

    icache_data_array icache_data_array_inst (
        .clock      (clock),
        .read_en    (data_read_en),
        .read_set   (data_read_set),
        .read_way   (data_read_way),
        .read_bank  (data_read_bank),
        .write_en   (data_write_en),
        .write_set  (data_write_set),
        .write_way  (data_write_way),
        .write_line (data_write_line),
        .read_data  (data_read_data)
    );

    // victim follows the tag read of the lookup cycle
    icache_victim_select icache_victim_select_inst (
        .clock      (clock),
        .reset_n    (reset_n),
        .way_valid  (tag_read_valid),
        .victim_way (victim_way)
    );

endmodule

`default_nettype wire

/* tb_icache_mem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_defs.svh"

module tb_icache_mem (
    input  wire                            clock,
    input  wire                            reset_n,
    input  wire                            mem_req_valid,
    output logic                           mem_req_ready,
    input  wire [`ICACHE_ADDR_BITS-1:0]    mem_req_addr,
    output logic                           mem_resp_valid,
    output logic [`ICACHE_LINE_BITS-1:0]   mem_resp_data
);

    int                           seed;
    int                           stall_left;  // ready held low for this many request cycles
    int                           delay_left;  // cycles until the line returns
    logic                         busy;
    logic                         take;
    logic                         pending;
    logic [`ICACHE_ADDR_BITS-1:0] line_addr;

    // every 32-bit lane holds its own byte address
    function automatic logic [`ICACHE_LINE_BITS-1:0] fill_line(input logic [31:0] base);
        logic [`ICACHE_LINE_BITS-1:0] line;
        for (int i = 0; i < `ICACHE_LINE_BITS / 32; i++) begin
            line[i*32 +: 32] = base + i * 4;
        end
        return line;
    endfunction

    initial begin
        seed           = 32'h2783;
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
        busy           = 1'b0;
        delay_left     = 0;
        line_addr      = '0;
        stall_left     = $unsigned($random(seed)) % 4;
        forever begin
            @(negedge clock);
            take    = mem_req_valid && mem_req_ready;  // accepted at the coming edge
            pending = mem_req_valid && !mem_req_ready;
            if (take) begin
                line_addr = mem_req_addr;
            end
            @(posedge clock);
            #1;
            mem_resp_valid = 1'b0;
            if (!reset_n) begin
                mem_req_ready = 1'b0;
                busy          = 1'b0;
            end else begin
                if (take) begin
                    mem_req_ready = 1'b0;
                    busy          = 1'b1;
                    delay_left    = $unsigned($random(seed)) % 6;
                    stall_left    = $unsigned($random(seed)) % 4;  // for the next request
                end else if (busy) begin
                    delay_left--;
                end else begin
                    if (pending && stall_left > 0) begin
                        stall_left--;
                    end
                    mem_req_ready = (stall_left == 0);
                end
                if (busy && delay_left == 0) begin
                    mem_resp_valid = 1'b1;  // one-cycle line pulse
                    mem_resp_data  = fill_line(line_addr);
                    busy           = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_icache.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_icache;

    localparam int FETCHES          = 15;  // including the flushed one
    localparam int CYCLES_PER_FETCH = 24;  // worst miss with stall and slow response
    localparam int CYCLE_LIMIT      = 8 + FETCHES * CYCLES_PER_FETCH;
    localparam int EXPECT_HIT       = 0;
    localparam int EXPECT_MISS      = 1;
    localparam int EXPECT_EITHER    = 2;

    logic               clock;
    logic               reset_n;
    logic               flush;
    logic               fetch_req_valid;
    logic               fetch_req_ready;
    icache_pkg::addr_t  fetch_req_addr;
    logic               fetch_done;
    icache_pkg::fetch_t fetch_data;
    logic               mem_req_valid;
    logic               mem_req_ready;
    icache_pkg::addr_t  mem_req_addr;
    logic               mem_resp_valid;
    icache_pkg::line_t  mem_resp_data;

    int                 errors;
    int                 fetch_count;
    int                 mem_accepts;
    int                 cycle_count;
    logic               fetch_active;  // a fetch is waiting for fetch_done
    icache_pkg::addr_t  cur_addr;
    logic               last_hit;      // hit result of the latest fetch

    icache_top icache_top_inst (
        .clock           (clock),
        .reset_n         (reset_n),
        .flush           (flush),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req_ready (fetch_req_ready),
        .fetch_req_addr  (fetch_req_addr),
        .fetch_done      (fetch_done),
        .fetch_data      (fetch_data),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_req_addr    (mem_req_addr),
        .mem_resp_valid  (mem_resp_valid),
        .mem_resp_data   (mem_resp_data)
    );

    tb_icache_mem mem_inst (
        .clock          (clock),
        .reset_n        (reset_n),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_addr   (mem_req_addr),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // four lanes holding their own byte addresses
    function automatic icache_pkg::fetch_t expected_word(input icache_pkg::addr_t addr);
        logic [31:0] base;
        base = {addr[31:4], 4'h0};
        return {base + 32'd12, base + 32'd8, base + 32'd4, base};
    endfunction

    a_reset_quiet: assert property (@(posedge clock) !reset_n |-> !fetch_done && !mem_req_valid)
        else begin errors++; $display("fetch_done or mem_req_valid high during reset"); end
    a_mem_hold: assert property (@(posedge clock) disable iff (!reset_n)
        mem_req_valid && !mem_req_ready && !flush |=> mem_req_valid && $stable(mem_req_addr))
        else begin errors++; $display("memory request dropped or changed while stalled"); end
    a_busy: assert property (@(posedge clock) disable iff (!reset_n)
        mem_req_valid |-> !fetch_req_ready)
        else begin errors++; $display("fetch_req_ready high during a memory request"); end
    a_done_pulse: assert property (@(posedge clock) disable iff (!reset_n)
        fetch_done |=> !fetch_done)
        else begin errors++; $display("fetch_done longer than one cycle"); end
    a_line_aligned: assert property (@(posedge clock) disable iff (!reset_n)
        mem_req_valid |-> mem_req_addr[5:0] == 6'd0)
        else begin errors++; $display("mem_req_addr not line aligned"); end

    // sampled on the falling edge before the accepting edge
    always @(negedge clock) begin
        if (reset_n && mem_req_valid && mem_req_ready) begin
            mem_accepts++;
            assert (mem_req_addr == {cur_addr[31:6], 6'b0}) else begin
                errors++;
                $display("ERR mem_req_addr: got %h expected %h",
                         mem_req_addr, {cur_addr[31:6], 6'b0});
            end
        end
        if (reset_n && fetch_done) begin
            assert (fetch_active) else begin
                errors++;
                $display("fetch_done pulsed with no fetch waiting for it");
            end
        end
    end

    task automatic fetch(input icache_pkg::addr_t addr, input int expect_kind,
                         output logic was_hit);
        int reqs_before;
        int wait_cycles;
        reqs_before     = mem_accepts;
        cur_addr        = addr;
        fetch_active    = 1'b1;
        fetch_req_valid = 1'b1;
        fetch_req_addr  = addr;
        @(negedge clock);
        while (!fetch_req_ready) @(negedge clock);
        @(posedge clock);  // accepted
        #1;
        fetch_req_valid = 1'b0;
        @(negedge clock);
        wait_cycles = 1;
        while (!fetch_done) begin
            @(negedge clock);
            wait_cycles++;
        end
        fetch_count++;
        was_hit = (mem_accepts == reqs_before);
        assert (fetch_data == expected_word(addr)) else begin
            errors++;
            $display("ERR fetch_data: got %h expected %h", fetch_data, expected_word(addr));
        end
        if (expect_kind == EXPECT_HIT) begin
            assert (was_hit && wait_cycles == 2) else begin
                errors++;
                $display("fetch of %h was no hit: %0d memory requests, done after %0d cycles",
                         addr, mem_accepts - reqs_before, wait_cycles);
            end
        end else begin
            assert (mem_accepts - reqs_before == 1 || expect_kind == EXPECT_EITHER) else begin
                errors++;
                $display("fetch of %h missed without exactly one memory request", addr);
            end
        end
        @(posedge clock);
        #1;
        fetch_active = 1'b0;
    endtask

    // flush after the line request is taken so the stale line gives no fetch_done
    task automatic flushed_fetch(input icache_pkg::addr_t addr);
        logic resp_seen;
        cur_addr        = addr;
        fetch_req_valid = 1'b1;
        fetch_req_addr  = addr;
        @(negedge clock);
        while (!fetch_req_ready) @(negedge clock);
        @(posedge clock);
        #1;
        fetch_req_valid = 1'b0;
        @(negedge clock);
        while (!(mem_req_valid && mem_req_ready)) @(negedge clock);
        @(posedge clock);
        #1;
        flush     = 1'b1;
        resp_seen = 1'b0;
        while (!resp_seen) begin
            @(negedge clock);
            resp_seen = mem_resp_valid;
            assert (!fetch_req_ready) else begin
                errors++;
                $display("fetch_req_ready high before the flushed line returned");
            end
            @(posedge clock);
            #1;
            flush = 1'b0;
        end
        repeat (3) @(posedge clock);  // a late fetch_done is caught by the monitor
        #1;
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout after %0d cycles, a fetch or memory handshake never finished",
                 cycle_count);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        errors          = 0;
        fetch_count     = 0;
        mem_accepts     = 0;
        fetch_active    = 1'b0;
        cur_addr        = '0;
        last_hit        = 1'b0;
        reset_n         = 1'b0;
        flush           = 1'b0;
        fetch_req_valid = 1'b0;
        fetch_req_addr  = '0;
        repeat (8) @(posedge clock);
        #1;
        reset_n = 1'b1;
        @(negedge clock);
        assert (fetch_req_ready) else begin
            errors++;
            $display("ERR fetch_req_ready: got %h expected 1", fetch_req_ready);
        end
        assert (!fetch_done && !mem_req_valid) else begin
            errors++;
            $display("fetch_done or mem_req_valid high right after reset");
        end
        @(posedge clock);
        #1;
        fetch(32'h0001_0084, EXPECT_MISS, last_hit);  // cold miss
        fetch(32'h0001_0094, EXPECT_HIT, last_hit);
        fetch(32'h0001_00A8, EXPECT_HIT, last_hit);
        fetch(32'h0001_00BC, EXPECT_HIT, last_hit);
        fetch(32'h0000_1040, EXPECT_MISS, last_hit);  // set 1 filled in both ways
        fetch(32'h0000_2050, EXPECT_MISS, last_hit);
        fetch(32'h0000_1070, EXPECT_HIT, last_hit);
        fetch(32'h0000_2044, EXPECT_HIT, last_hit);
        fetch(32'h0000_3060, EXPECT_MISS, last_hit);  // third tag evicts one
        fetch(32'h0000_3048, EXPECT_HIT, last_hit);
        fetch(32'h0000_1040, EXPECT_EITHER, last_hit);
        fetch(32'h0000_2040, last_hit ? EXPECT_MISS : EXPECT_EITHER, last_hit);
        flushed_fetch(32'h0002_0110);
        fetch(32'h0002_0110, EXPECT_MISS, last_hit);  // flushed line misses again
        fetch(32'h0002_0120, EXPECT_HIT, last_hit);
        $display("%0d fetches, %0d memory requests, %0d errors",
                 fetch_count, mem_accepts, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
icache_pkg.sv
icache_tag_array.sv
icache_data_array.sv
icache_victim_select.sv
icache_ctrl.sv
icache_top.sv
tb_icache_mem.sv
tb_icache.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := tb_icache
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(FLIST) *.sv *.svh
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
